/* Bender.yml */
package:
  name: pce_io

sources:
  - pce_io_pkg.sv
  - ctrl_bus_if.sv
  - pad_port_mux.sv
  - mouse_tracker.sv
  - cheat_code_loader.sv
  - audio_mixer.sv
  - pce_io_top.sv
  - target: test
    files:
      - pce_io_chk.sv
      - tb_pce_io.sv

/* audio_mixer.sv */
// Two-stage stereo mix of CD-DA, PSG and ADPCM with 1.25 gain
module audio_mixer import pce_io_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  sample_t cdda_l,
	input  sample_t cdda_r,
	input  sample_t psg_l,
	input  sample_t psg_r,
	input  sample_t adpcm,
	output sample_t audio_l,
	output sample_t audio_r
);

	mix_acc_t pre_l;
	mix_acc_t pre_r;
	mix_acc_t mix_l;
	mix_acc_t mix_r;

	// ========================================
	// Sum, then 1 + 1/4 gain
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_l <= '0;
			pre_r <= '0;
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			// ADPCM is mono and feeds both sides
			pre_l <= mix_acc_t'(cdda_l) + mix_acc_t'(psg_l) + mix_acc_t'(adpcm);
			pre_r <= mix_acc_t'(cdda_r) + mix_acc_t'(psg_r) + mix_acc_t'(adpcm);
			mix_l <= pre_l + (pre_l >>> 2);
			mix_r <= pre_r + (pre_r >>> 2);
		end
	end

	// Drop the headroom bits at the bottom
	assign audio_l = mix_l[SAMPLE_W+MIX_HEADROOM-1:MIX_HEADROOM];
	assign audio_r = mix_r[SAMPLE_W+MIX_HEADROOM-1:MIX_HEADROOM];

endmodule

/* cheat_code_loader.sv */
// Cheat code assembly from 16-bit download words with a load strobe
module cheat_code_loader import pce_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        code_download,
	input  logic        ioctl_wr,
	input  logic [3:0]  ioctl_addr,
	input  logic [15:0] ioctl_dout,
	output cheat_code_t code,
	output logic        code_load
);

	logic code_wr;

	assign code_wr = code_download & ioctl_wr;

	// ========================================
	// Word placement
	// ========================================
	// Low half of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_wr && !ioctl_addr[0]) begin
			case (ioctl_addr[3:1])
				3'd0: code.flags[15:0]    <= ioctl_dout;
				3'd1: code.flags[31:16]   <= ioctl_dout;
				3'd2: code.address[15:0]  <= ioctl_dout;
				3'd3: code.address[31:16] <= ioctl_dout;
				3'd4: code.compare[15:0]  <= ioctl_dout;
				3'd5: code.compare[31:16] <= ioctl_dout;
				3'd6: code.replace[15:0]  <= ioctl_dout;
				default: code.replace[31:16] <= ioctl_dout;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_load <= 1'b0;
		else
			code_load <= code_wr && (ioctl_addr == CODE_LAST_OFFSET);
	end

endmodule

/* ctrl_bus_if.sv */
// Pad select/clear lines and mouse reply nibble between port and mouse logic
interface ctrl_bus_if import pce_io_pkg::*; ();

	// Copies of the console joy_out pair
	logic sel;
	logic clr;

	// Single-cycle pulse on a rising clear
	logic clr_rise;

	// Active-low mouse reply
	// With sel high this is the current motion nibble,
	// with sel low only bits 1:0 matter (right, left buttons)
	pad_nibble_t mouse_nibble;

	modport port_side (
		output sel,
		output clr,
		output clr_rise,
		input  mouse_nibble
	);

	modport mouse_side (
		input  sel,
		input  clr,
		input  clr_rise,
		output mouse_nibble
	);

endinterface

/* mouse_tracker.sv */
// PC Engine mouse: PS/2 motion capture, idle timeout and nibble sequencing
module mouse_tracker import pce_io_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  ps2_mouse_t     ps2_mouse,
	ctrl_bus_if.mouse_side bus
);

	ps2_mouse_t              ps2_q;
	logic                    stb_prev;
	logic [7:0]              pend_x;
	logic [7:0]              pend_y;
	logic [7:0]              cur_x;
	logic [7:0]              cur_y;
	logic [MOUSE_IDLE_W-1:0] idle_cnt;
	logic [1:0]              step;
	pad_nibble_t             motion;

	// Report input stage
	always_ff @(posedge clk_sys) begin
		ps2_q <= ps2_mouse;
	end

	// ========================================
	// Capture, timeout and step counter
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stb_prev <= 1'b0;
			idle_cnt <= '0;
			step     <= 2'd3;
			pend_x   <= '0;
			pend_y   <= '0;
			cur_x    <= '0;
			cur_y    <= '0;
		end else begin
			stb_prev <= ps2_q[MS_STROBE];

			// Long clear-low gap means the console gave up mid-read
			if (bus.clr)
				idle_cnt <= '0;
			else if (!(&idle_cnt))
				idle_cnt <= idle_cnt + 1'b1;

			if (&idle_cnt)
				step <= 2'd3;

			if (bus.clr_rise) begin
				step <= step + 1'b1;
				// End of a four-step read, hand pending motion over
				if (step == 2'd3) begin
					cur_x  <= pend_x;
					cur_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// New report wins over the handover clear
			if (ps2_q[MS_STROBE] != stb_prev) begin
				pend_x <= 8'd0 - ps2_q[MS_X_LSB +: 8];
				pend_y <= ps2_q[MS_Y_LSB +: 8];
			end
		end
	end

	always_comb begin
		case (step)
			2'd0:    motion = cur_x[7:4];
			2'd1:    motion = cur_x[3:0];
			2'd2:    motion = cur_y[7:4];
			default: motion = cur_y[3:0];
		endcase
	end

	// Buttons ride on the low bits while sel is low
	assign bus.mouse_nibble = bus.sel ? motion :
		{2'b11, ~ps2_q[MS_BTN_LEFT], ~ps2_q[MS_BTN_RIGHT]};

endmodule

/* pad_port_mux.sv */
// Controller port: multitap stepping, 6-button phase and console reply nibble
module pad_port_mux import pce_io_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  pad_buttons_t  joy_0,
	input  pad_buttons_t  joy_1,
	input  pad_buttons_t  joy_2,
	input  pad_buttons_t  joy_3,
	input  pad_buttons_t  joy_4,
	input  logic          multitap_en,
	input  logic          six_button_en,
	input  logic [1:0]    joy_out,
	output pad_nibble_t   joy_in,
	input  logic          mouse_en,
	ctrl_bus_if.port_side bus
);

	logic [1:0]        joy_prev;
	logic [PORT_W-1:0] port;
	logic              phase;
	logic              sel_rise;
	logic              pad_valid;
	pad_buttons_t      pad;
	pad_nibble_t       nibble;

	// ========================================
	// Edge detection on joy_out
	// ========================================
	assign bus.sel      = joy_out[0];
	assign bus.clr      = joy_out[1];
	assign bus.clr_rise = joy_out[1] & ~joy_prev[1];
	assign sel_rise     = joy_out[0] & ~joy_prev[0];

	// Ports past the last pad are empty
	assign pad_valid = port < PORT_W'(NUM_PADS);

	always_comb begin
		case (port)
			3'd1:    pad = joy_1;
			3'd2:    pad = joy_2;
			3'd3:    pad = joy_3;
			3'd4:    pad = joy_4;
			default: pad = joy_0;
		endcase
	end

	// ========================================
	// Reply nibble, active low
	// ========================================
	always_comb begin
		if (!pad_valid) begin
			nibble = joy_out[0] ? 4'b0000 : 4'b1111;
		end else if (mouse_en && port == '0) begin
			// Mouse ignores the 6-button phase
			if (joy_out[0])
				nibble = bus.mouse_nibble;
			else
				nibble = {~joy_0[BTN_RUN], ~joy_0[BTN_SELECT], bus.mouse_nibble[1:0]};
		end else if (!phase) begin
			if (joy_out[0])
				nibble = ~{pad[BTN_LEFT], pad[BTN_DOWN], pad[BTN_RIGHT], pad[BTN_UP]};
			else
				nibble = ~{pad[BTN_RUN], pad[BTN_SELECT], pad[BTN_II], pad[BTN_I]};
		end else begin
			// Extra buttons on the low half, all lines low as the 6-button ID
			if (joy_out[0])
				nibble = 4'b0000;
			else
				nibble = ~{pad[BTN_VI], pad[BTN_V], pad[BTN_IV], pad[BTN_III]};
		end
	end

	// Port counter, phase and latched reply
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_prev <= '0;
			port     <= '0;
			phase    <= 1'b0;
			joy_in   <= '0;
		end else begin
			joy_prev <= joy_out;
			if (joy_out[1]) begin
				port   <= '0;
				joy_in <= '0;
				if (!joy_prev[1])
					phase <= ~phase & six_button_en;
			end else begin
				joy_in <= nibble;
				if (sel_rise && multitap_en)
					port <= port + 1'b1;
			end
		end
	end

endmodule

/* pce_io_chk.sv */
// Bound assertions on the console I/O top level: clear reply, load strobe, reset state
module pce_io_chk import pce_io_pkg::*; (
	input logic        clk_sys,
	input logic        reset,
	input logic [1:0]  joy_out,
	input pad_nibble_t joy_in,
	input logic        code_load
);
	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions
	int unsigned assert_errors = 0;

	// All reply lines low in the cycle after clear is seen
	clr_reply_zero: assert property (@(posedge clk_sys) disable iff (reset)
		joy_out[1] |=> joy_in == '0) else begin
		assert_errors++;
		$error("joy_in not zero in the cycle after clear");
	end

	// Load strobe is a single-cycle pulse
	load_single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		code_load |=> !code_load) else begin
		assert_errors++;
		$error("code_load high for two cycles in a row");
	end

	reset_reply_zero: assert property (@(posedge clk_sys)
		reset |=> joy_in == '0) else begin
		assert_errors++;
		$error("joy_in not zero one cycle after reset");
	end

endmodule

bind pce_io_top pce_io_chk u_pce_io_chk (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.joy_out   (joy_out),
	.joy_in    (joy_in),
	.code_load (code_load)
);

/* pce_io_pkg.sv */
// Widths, limits, bit positions and data types for the console I/O logic
package pce_io_pkg;

	// ========================================
	// Widths and limits
	// ========================================
	localparam int NUM_PADS     = 5;
	localparam int PORT_W       = 3;
	localparam int MOUSE_IDLE_W = 15;
	localparam int CODE_WORDS   = 8;
	localparam int SAMPLE_W     = 16;
	localparam int MIX_HEADROOM = 2;

	// Byte offset of the last download word
	localparam logic [3:0] CODE_LAST_OFFSET = 4'((CODE_WORDS - 1) * 2);

	// ========================================
	// Host pad bit order
	// ========================================
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_I      = 4;
	localparam int BTN_II     = 5;
	localparam int BTN_SELECT = 6;
	localparam int BTN_RUN    = 7;
	localparam int BTN_III    = 8;
	localparam int BTN_IV     = 9;
	localparam int BTN_V      = 10;
	localparam int BTN_VI     = 11;

	// PS/2 mouse report fields
	localparam int MS_BTN_LEFT  = 0;
	localparam int MS_BTN_RIGHT = 1;
	localparam int MS_X_LSB     = 8;
	localparam int MS_Y_LSB     = 16;
	localparam int MS_STROBE    = 24;

	// ========================================
	// Types
	// ========================================
	typedef logic [11:0] pad_buttons_t;
	typedef logic [3:0]  pad_nibble_t;
	typedef logic [24:0] ps2_mouse_t;

	// Same field order as the download stream, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef logic signed [SAMPLE_W-1:0]              sample_t;
	typedef logic signed [SAMPLE_W+MIX_HEADROOM-1:0] mix_acc_t;

endpackage

/* pce_io_top.sv */
// Top level of the console I/O logic: controller port, mouse, cheats, audio
module pce_io_top import pce_io_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,

	// Controller port
	input  pad_buttons_t joy_0,
	input  pad_buttons_t joy_1,
	input  pad_buttons_t joy_2,
	input  pad_buttons_t joy_3,
	input  pad_buttons_t joy_4,
	input  logic         multitap_en,
	input  logic         six_button_en,
	input  logic         mouse_en,
	input  logic [1:0]   joy_out,
	output pad_nibble_t  joy_in,
	input  ps2_mouse_t   ps2_mouse,

	// Cheat download
	input  logic         code_download,
	input  logic         ioctl_wr,
	input  logic [3:0]   ioctl_addr,
	input  logic [15:0]  ioctl_dout,
	output cheat_code_t  code,
	output logic         code_load,

	// Audio
	input  sample_t      cdda_l,
	input  sample_t      cdda_r,
	input  sample_t      psg_l,
	input  sample_t      psg_r,
	input  sample_t      adpcm,
	output sample_t      audio_l,
	output sample_t      audio_r
);

	ctrl_bus_if bus ();

	// ========================================
	// Controller port and mouse
	// ========================================
	pad_port_mux u_pad_port_mux (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.joy_0         (joy_0),
		.joy_1         (joy_1),
		.joy_2         (joy_2),
		.joy_3         (joy_3),
		.joy_4         (joy_4),
		.multitap_en   (multitap_en),
		.six_button_en (six_button_en),
		.joy_out       (joy_out),
		.joy_in        (joy_in),
		.mouse_en      (mouse_en),
		.bus           (bus.port_side)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_mouse (ps2_mouse),
		.bus       (bus.mouse_side)
	);

	// ========================================
	// Cheats and audio
	// ========================================
	cheat_code_loader u_cheat_code_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.code          (code),
		.code_load     (code_load)
	);

	audio_mixer u_audio_mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cdda_l  (cdda_l),
		.cdda_r  (cdda_r),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.adpcm   (adpcm),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

/* tb.f */
pce_io_pkg.sv
ctrl_bus_if.sv
pad_port_mux.sv
mouse_tracker.sv
cheat_code_loader.sv
audio_mixer.sv
pce_io_top.sv
pce_io_chk.sv
tb_pce_io.sv

/* tb_pce_io.sv */
// Testbench for the console I/O top level with pad port, multitap, mouse, cheat and audio tests
module tb_pce_io import pce_io_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic         clk_sys;
	logic         reset;
	pad_buttons_t joy_0;
	pad_buttons_t joy_1;
	pad_buttons_t joy_2;
	pad_buttons_t joy_3;
	pad_buttons_t joy_4;
	logic         multitap_en;
	logic         six_button_en;
	logic         mouse_en;
	logic [1:0]   joy_out;
	pad_nibble_t  joy_in;
	ps2_mouse_t   ps2_mouse;
	logic         code_download;
	logic         ioctl_wr;
	logic [3:0]   ioctl_addr;
	logic [15:0]  ioctl_dout;
	cheat_code_t  code;
	logic         code_load;
	sample_t      cdda_l;
	sample_t      cdda_r;
	sample_t      psg_l;
	sample_t      psg_r;
	sample_t      adpcm;
	sample_t      audio_l;
	sample_t      audio_r;

	int   seed = 32'h2b32;
	int   errors = 0;
	int   checks = 0;
	int   tests = 0;
	int   test_base = 0;
	logic exp_phase = 1'b0;

	pce_io_top UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================
	// Expected values and compare tasks
	// ========================================
	// Host bit order is right, left, down, up, I, II, Select, Run, III, IV, V, VI
	function automatic pad_nibble_t pad_reply(pad_buttons_t b, logic sel, logic phase);
		if (!phase && !sel)
			return ~{b[7], b[6], b[5], b[4]};
		if (!phase)
			return ~{b[1], b[2], b[0], b[3]};
		if (!sel)
			return ~{b[11], b[10], b[9], b[8]};
		return 4'b0000;
	endfunction

	// Sum with a gain of 1.25, then drop two bits
	function automatic sample_t mix_expect(sample_t a, sample_t b, sample_t c);
		int s;
		s = int'(a) + int'(b) + int'(c);
		s = s + (s >>> 2);
		return sample_t'(s >>> 2);
	endfunction

	task automatic check_nibble(string name, pad_nibble_t got, pad_nibble_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_code(string name, cheat_code_t got, cheat_code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_sample(string name, sample_t got, sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(string name);
		tests++;
		if (errors == test_base)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// ========================================
	// Port helpers
	// ========================================
	task automatic drive_joy_out(logic [1:0] lines);
		@(posedge clk_sys);
		joy_out <= lines;
	endtask

	// Reply is registered one cycle after the lines are taken
	task automatic expect_reply(logic [1:0] lines, pad_nibble_t exp);
		drive_joy_out(lines);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_nibble("joy_in", joy_in, exp);
	endtask

	task automatic pulse_clear();
		drive_joy_out(2'b10);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_nibble("joy_in", joy_in, 4'h0);
		exp_phase = six_button_en ? !exp_phase : 1'b0;
		drive_joy_out(2'b00);
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic single_pad_test();
		pad_buttons_t buttons;
		for (int i = 0; i < 4; i++) begin
			buttons = pad_buttons_t'($random(seed));
			@(posedge clk_sys);
			joy_0 <= buttons;
			expect_reply(2'b00, pad_reply(buttons, 1'b0, 1'b0));
			expect_reply(2'b01, pad_reply(buttons, 1'b1, 1'b0));
		end
		report_test("single pad");
	endtask

	task automatic multitap_test();
		pad_buttons_t pads [NUM_PADS];
		foreach (pads[p])
			pads[p] = pad_buttons_t'($random(seed));
		@(posedge clk_sys);
		multitap_en <= 1'b1;
		joy_0 <= pads[0];
		joy_1 <= pads[1];
		joy_2 <= pads[2];
		joy_3 <= pads[3];
		joy_4 <= pads[4];
		pulse_clear();
		// Each sel rise moves on to the next port
		for (int p = 0; p < NUM_PADS; p++) begin
			expect_reply(2'b00, pad_reply(pads[p], 1'b0, 1'b0));
			expect_reply(2'b01, pad_reply(pads[p], 1'b1, 1'b0));
		end
		expect_reply(2'b00, 4'b1111);
		expect_reply(2'b01, 4'b0000);
		@(posedge clk_sys);
		multitap_en <= 1'b0;
		report_test("multitap");
	endtask

	task automatic six_button_test();
		@(posedge clk_sys);
		six_button_en <= 1'b1;
		joy_0 <= pad_buttons_t'($random(seed));
		for (int i = 0; i < 4; i++) begin
			pulse_clear();
			expect_reply(2'b00, pad_reply(joy_0, 1'b0, exp_phase));
			expect_reply(2'b01, pad_reply(joy_0, 1'b1, exp_phase));
		end
		@(posedge clk_sys);
		six_button_en <= 1'b0;
		pulse_clear();
		report_test("six button");
	endtask

	task automatic mouse_test();
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  btn;
		logic [7:0]  nx;
		pad_nibble_t motion [4];
		x = 8'($random(seed));
		y = 8'($random(seed));
		btn = 8'($random(seed));
		nx = ~x + 8'd1;
		motion = '{nx[7:4], nx[3:0], y[7:4], y[3:0]};
		@(posedge clk_sys);
		mouse_en <= 1'b1;
		joy_0 <= pad_buttons_t'($random(seed));
		// Idle timeout parks the step counter at 3
		repeat ((1 << MOUSE_IDLE_W) + 4) @(posedge clk_sys);
		ps2_mouse <= {~ps2_mouse[24], y, x, btn};
		repeat (2) @(posedge clk_sys);
		for (int s = 0; s < 4; s++) begin
			pulse_clear();
			expect_reply(2'b00, ~{joy_0[7], joy_0[6], btn[0], btn[1]});
			expect_reply(2'b01, motion[s]);
		end
		@(posedge clk_sys);
		mouse_en <= 1'b0;
		report_test("mouse");
	endtask

	task automatic cheat_code_test();
		logic [15:0] words [CODE_WORDS];
		cheat_code_t exp;
		int          waited;
		@(posedge clk_sys);
		code_download <= 1'b1;
		for (int i = 0; i < CODE_WORDS; i++) begin
			words[i] = 16'($random(seed));
			@(posedge clk_sys);
			ioctl_addr <= 4'(2 * i);
			ioctl_dout <= words[i];
			ioctl_wr   <= 1'b1;
		end
		// Last write is taken on this edge
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		waited = 0;
		@(negedge clk_sys);
		while (!code_load && waited < 10) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!code_load) begin
			errors++;
			$display("timeout: code_load did not rise within 10 cycles of the last write");
		end else if (waited != 0) begin
			errors++;
			$display("code_load rose %0d cycles later than one cycle after the last write",
				waited);
		end
		exp.flags   = {words[1], words[0]};
		exp.address = {words[3], words[2]};
		exp.compare = {words[5], words[4]};
		exp.replace = {words[7], words[6]};
		check_code("code", code, exp);
		@(posedge clk_sys);
		code_download <= 1'b0;
		report_test("cheat code");
	endtask

	task automatic audio_test();
		sample_t cl [8];
		sample_t cr [8];
		sample_t pl [8];
		sample_t pr [8];
		sample_t ad [8];
		for (int i = 0; i < 10; i++) begin
			@(posedge clk_sys);
			if (i < 8) begin
				cl[i] = sample_t'($random(seed));
				cr[i] = sample_t'($random(seed));
				pl[i] = sample_t'($random(seed));
				pr[i] = sample_t'($random(seed));
				ad[i] = sample_t'($random(seed));
				cdda_l <= cl[i];
				cdda_r <= cr[i];
				psg_l  <= pl[i];
				psg_r  <= pr[i];
				adpcm  <= ad[i];
			end
			@(negedge clk_sys);
			// Two-cycle latency
			if (i >= 2) begin
				check_sample("audio_l", audio_l, mix_expect(cl[i-2], pl[i-2], ad[i-2]));
				check_sample("audio_r", audio_r, mix_expect(cr[i-2], pr[i-2], ad[i-2]));
			end
		end
		report_test("audio");
	endtask

	initial begin
		reset = 1'b1;
		{joy_0, joy_1, joy_2, joy_3, joy_4} = '0;
		multitap_en = 1'b0;
		six_button_en = 1'b0;
		mouse_en = 1'b0;
		joy_out = 2'b00;
		ps2_mouse = '0;
		code_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		{cdda_l, cdda_r, psg_l, psg_r, adpcm} = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		single_pad_test();
		multitap_test();
		six_button_test();
		mouse_test();
		cheat_code_test();
		audio_test();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, UUT.u_pce_io_chk.assert_errors);
		if (errors == 0 && UUT.u_pce_io_chk.assert_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
